// ==== fizzle_display.f ====
+incdir+common
common/fizzle_pkg.sv
display/display_timing.sv
display/line_scaler.sv
framebuffer/framebuffer.sv
logic/clut.sv
logic/fizzle_ctrl.sv
logic/fizzle_display_top.sv
bench/tb_clock.sv
bench/fizzle_checker.sv
bench/fizzle_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary -j 0
TOP       = fizzle_tb
FILELIST  = fizzle_display.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)

SOURCES = $(shell grep -v '^+' $(FILELIST)) common/fizzle_defs.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q '^Test OK$$'

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/fizzle_testdata.mem ====
// one hex word per line
// 0..15 palette colours rgb, 16 fade index, 17 new colour 0, 18 frame count
123
f00
0f0
00f
ff0
0ff
f0f
fff
800
080
008
880
088
808
444
abc
5
9e7
12

// ==== bench/fizzle_tb.sv ====
/* fizzle display testbench
   palette load, palette rewrite and a full fade, checked frame by frame */
module fizzle_tb import fizzle_pkg::*; ();

    logic         clk_sys, rst_n;
    logic         fade_start, pal_we;
    cidx_t        fade_colr, pal_idx;
    colr_t        pal_colr;
    logic         hsync, vsync, de, frame, fade_done;
    chan_t        vga_r, vga_g, vga_b;
    logic [15:0]  testdata [19];
    logic [191:0] pal_flat;
    colr_t        pal0_exp;
    logic         pal_upd, armed, finish, report_done;
    logic [7:0]   tests_failed;
    logic [31:0]  lfsr_state;
    int           n_frames, idle_frames, cycles;
    int           limit;

    tb_clock clock0 (.clk_sys, .rst_n);

    fizzle_display_top dut0 (.clk_sys, .rst_n, .fade_start, .fade_colr, .pal_we,
        .pal_idx, .pal_colr, .hsync, .vsync, .de, .frame, .vga_r, .vga_g, .vga_b,
        .fade_done);

    fizzle_checker check0 (.clk_sys, .hsync, .vsync, .de, .frame, .fade_done,
        .fade_start, .vga_r, .vga_g, .vga_b, .pal_flat, .fade_idx(fade_colr),
        .pal0_exp, .pal_upd, .armed, .finish, .tests_failed, .report_done);

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic next_cycle();
        @(posedge clk_sys);
        #5;
    endtask

    task automatic write_palette(input cidx_t idx, input colr_t c);
        pal_we   = 1'b1;
        pal_idx  = idx;
        pal_colr = c;
        next_cycle();
        pal_we   = 1'b0;
    endtask

    task automatic wait_frames(input int n);
        repeat (n) begin
            next_cycle();
            while (frame !== 1'b1) next_cycle();
        end
    endtask

    // limit from the run length in the testdata
    always @(posedge clk_sys) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: no result after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        $readmemh("bench/fizzle_testdata.mem", testdata);
        n_frames   = int'(testdata[18]);
        limit      = (n_frames + 8) * 1120;
        lfsr_state = 32'h9b1cfbd7;
        for (int i = 0; i < 16; i++) pal_flat[i * 12 +: 12] = testdata[i][11:0];
        fade_start = 1'b0;
        fade_colr  = testdata[16][3:0];
        pal_we     = 1'b0;
        pal_idx    = '0;
        pal_colr   = '0;
        pal0_exp   = testdata[0][11:0];
        pal_upd    = 1'b0;
        armed      = 1'b0;
        finish     = 1'b0;
        @(posedge rst_n);
        next_cycle();
        for (int i = 0; i < 16; i++) write_palette(cidx_t'(i), testdata[i][11:0]);
        wait_frames(2);                           // line stores hold real rows now
        armed = 1'b1;
        idle_frames = 1;
        repeat (2) begin                          // one bit per step
            lfsr_state  = lfsr_step(lfsr_state);
            idle_frames = idle_frames * 2 + int'(lfsr_state[0]) - 1;
        end
        wait_frames(idle_frames + 1);
        next_cycle();
        pal0_exp = testdata[17][11:0];
        pal_upd  = 1'b1;
        write_palette('0, testdata[17][11:0]);
        wait_frames(2);
        next_cycle();
        fade_start = 1'b1;
        next_cycle();
        fade_start = 1'b0;
        while (fade_done !== 1'b1) next_cycle();
        wait_frames(4);
        finish = 1'b1;
        while (report_done !== 1'b1) next_cycle();
        if (tests_failed == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/fizzle_checker.sv ====
/* output checker
   rebuilds each frame from the dut outputs and compares it with the rules */
`include "fizzle_defs.svh"

module fizzle_checker import fizzle_pkg::*; (
    input  logic         clk_sys,
    input  logic         hsync, vsync, de, frame, fade_done, fade_start,
    input  chan_t        vga_r, vga_g, vga_b,
    input  logic [191:0] pal_flat,     // expected palette, entry 0 lowest
    input  cidx_t        fade_idx,
    input  colr_t        pal0_exp,     // current colour of index 0
    input  logic         pal_upd, armed, finish,
    output logic [7:0]   tests_failed,
    output logic         report_done
);

    localparam int FRAME = `H_TOTAL * `V_TOTAL;

    colr_t img [`V_ACTIVE][`H_ACTIVE];
    int    errs [6];
    int    frames [6];
    bit    shown [6];
    int    pos, last_faded, done_frames;
    bit    in_frame, f_dirty, f_fade, fade_hit, comp_done, upd_prev, fin_prev;
    int    f_done;
    colr_t pal0_prev, pix, fade_c;

    function automatic string test_name(input int t);
        case (t)
            0: return "frame geometry";
            1: return "initial image";
            2: return "scaling";
            3: return "fade progress";
            4: return "fade completion";
            default: return "palette update";
        endcase
    endfunction

    task automatic fail_val(input int t, input string sig, input int x, input int y,
                            input logic [11:0] exp_v, input logic [11:0] got_v);
        if (errs[t] < 5) $display("error %s at (%0d,%0d) expected %h got %h",
                                  sig, x, y, exp_v, got_v);
        errs[t]++;
    endtask

    task automatic fail_msg(input int t, input string msg);
        $display("%s: %s", test_name(t), msg);
        errs[t]++;
    endtask

    task automatic print_test(input int t);
        if (shown[t]) return;
        if (frames[t] == 0) fail_msg(t, "no frame was checked");
        shown[t] = 1;
        $display("test %-16s %0d frames, %0d errors, %s", test_name(t), frames[t],
                 errs[t], (errs[t] == 0) ? "pass" : "fail");
    endtask

    // one cycle of output, position counted from the frame pulse
    task automatic sample();
        int   x, y;
        logic exp_de, exp_hs, exp_vs;
        x      = pos % `H_TOTAL;
        y      = pos / `H_TOTAL;
        exp_de = (x < `H_ACTIVE && y < `V_ACTIVE);
        exp_hs = (x >= 34 && x < 38);   // after the front porch
        exp_vs = (y >= 25 && y < 27);
        pix = {vga_r, vga_g, vga_b};
        if (pos == FRAME) fail_msg(0, "frame ran past 1120 cycles");
        if (de !== exp_de) fail_val(0, "de", x, y, 12'(exp_de), 12'(de));
        if (hsync !== exp_hs) fail_val(0, "hsync", x, y, 12'(exp_hs), 12'(hsync));
        if (vsync !== exp_vs) fail_val(0, "vsync", x, y, 12'(exp_vs), 12'(vsync));
        if (de !== 1'b1 && pix !== 12'h000) fail_val(0, "colr", x, y, 12'h000, pix);
        if (pos < FRAME && de === 1'b1) img[y][x] = pix;
        if (pal0_exp !== pal0_prev) f_dirty = 1;  // palette moved mid frame
        if (fade_start) f_fade = 1;
        pos++;
    endtask

    task automatic check_uniform(input int t, input colr_t c);
        for (int y = 0; y < `V_ACTIVE; y++)
            for (int x = 0; x < `H_ACTIVE; x++)
                if (img[y][x] !== c) fail_val(t, "colr", x, y, c, img[y][x]);
        frames[t]++;
    endtask

    task automatic end_frame();
        int faded;
        if (pos != FRAME) fail_msg(0, $sformatf("frame lasted %0d cycles, not 1120", pos));
        frames[0]++;
        if (!f_dirty) begin
            for (int y = 0; y < `V_ACTIVE; y += 2)      // 2x2 blocks
                for (int x = 0; x < `H_ACTIVE; x += 2)
                    for (int k = 1; k < 4; k++)
                        if (img[y + k / 2][x + k % 2] !== img[y][x])
                            fail_val(2, "colr", x + k % 2, y + k / 2, img[y][x],
                                     img[y + k / 2][x + k % 2]);
            frames[2]++;
        end
        if (!f_dirty && !f_fade) begin
            check_uniform(pal_upd ? 5 : 1, pal0_exp);
        end else if (f_fade && !comp_done) begin
            faded = 0;
            for (int y = 0; y < `V_ACTIVE; y++)
                for (int x = 0; x < `H_ACTIVE; x++)
                    if (img[y][x] === fade_c) faded++;
                    else if (img[y][x] !== pal0_exp)
                        fail_val(3, "colr", x, y, pal0_exp, img[y][x]);
            if (faded < last_faded)
                fail_msg(3, $sformatf("faded pixels dropped from %0d to %0d",
                                      last_faded, faded));
            last_faded = faded;
            frames[3]++;
            // first full frame after done shows the finished image
            if (f_done >= 1) begin
                check_uniform(4, fade_c);
                comp_done = 1;
                print_test(3);
                print_test(4);
            end
        end
    endtask

    initial begin
        tests_failed = '0;
        report_done  = 1'b0;
    end

    // outputs are settled at the falling edge
    always @(negedge clk_sys) begin
        fade_c = pal_flat[fade_idx * 12 +: 12];
        if (fade_done && frame) done_frames++;
        if (fade_start && !fade_hit) begin
            fade_hit = 1;
            print_test(5);
        end
        if (pal_upd && !upd_prev) print_test(1);
        upd_prev = pal_upd;
        if (frame) begin
            if (in_frame) end_frame();
            in_frame  = armed;
            pos       = 0;
            f_dirty   = 0;
            f_fade    = fade_hit;
            f_done    = done_frames;
        end
        if (in_frame) sample();
        pal0_prev = pal0_exp;
        if (finish && !fin_prev) begin
            if (!comp_done) fail_msg(4, "no full frame after fade_done was checked");
            for (int t = 0; t < 6; t++) print_test(t);
            for (int t = 0; t < 6; t++) if (errs[t] != 0) tests_failed++;
            $display("tests run 6, passed %0d, failed %0d", 6 - tests_failed, tests_failed);
            report_done = 1'b1;
        end
        fin_prev = finish;
    end

endmodule

// ==== bench/tb_clock.sv ====
/* testbench clock and reset
   40 unit clock, reset held low for five cycles */
module tb_clock (
    output logic clk_sys,
    output logic rst_n
);

    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk_sys);
        #5 rst_n = 1'b1;  // same offset as the other inputs
    end

endmodule

// ==== logic/fizzle_display_top.sv ====
/* fizzle display top level
   timing, control, framebuffer, line scaler and palette on one clock */
module fizzle_display_top import fizzle_pkg::*; (
    input  logic  clk_sys,
    input  logic  rst_n,
    input  logic  fade_start,
    input  cidx_t fade_colr,
    input  logic  pal_we,
    input  cidx_t pal_idx,
    input  colr_t pal_colr,
    output logic  hsync,
    output logic  vsync,
    output logic  de,
    output logic  frame,
    output chan_t vga_r,
    output chan_t vga_g,
    output chan_t vga_b,
    output logic  fade_done
);

    coord_t   sx, sy;
    logic     hsync_raw, vsync_raw, de_raw;
    logic     line_start, frame_start;
    logic     fb_we;
    fb_addr_t fb_waddr;
    cidx_t    fb_wdata;
    logic     fetch_start;
    fb_row_t  fetch_row;
    logic     pix_valid, credit_return;
    cidx_t    pix_data;
    logic     buf_swap;
    fb_col_t  rd_col;
    cidx_t    lb_cidx;
    logic     paint_d;
    colr_t    colr;

    display_timing timing0 (.clk_sys, .rst_n, .sx, .sy, .hsync_raw, .vsync_raw,
        .de_raw, .line_start, .frame_start);

    fizzle_ctrl ctrl0 (.clk_sys, .rst_n, .sx, .sy, .hsync_raw, .vsync_raw, .de_raw,
        .line_start, .frame_start, .fade_start, .fade_colr, .fb_we, .fb_waddr,
        .fb_wdata, .fetch_start, .fetch_row, .buf_swap, .rd_col, .paint_d,
        .hsync, .vsync, .de, .frame, .fade_done);

    framebuffer fb0 (.clk_sys, .rst_n, .fb_we, .fb_waddr, .fb_wdata, .fetch_start,
        .fetch_row, .credit_return, .pix_valid, .pix_data);

    line_scaler scaler0 (.clk_sys, .rst_n, .pix_valid, .pix_data, .credit_return,
        .buf_swap, .rd_col, .lb_cidx);

    clut clut0 (.clk_sys, .pal_we, .pal_idx, .pal_colr, .cidx(lb_cidx),
        .paint(paint_d), .colr);

    // split the packed colour into channels
    assign vga_r = colr[11:8];
    assign vga_g = colr[7:4];
    assign vga_b = colr[3:0];

endmodule

// ==== logic/fizzle_ctrl.sv ====
/* fizzle control
   runs the lfsr fade, schedules row fetches and swaps, aligns syncs to colour */
`include "fizzle_defs.svh"

module fizzle_ctrl import fizzle_pkg::*; (
    input  logic     clk_sys,
    input  logic     rst_n,
    input  coord_t   sx,
    input  coord_t   sy,
    input  logic     hsync_raw,
    input  logic     vsync_raw,
    input  logic     de_raw,
    input  logic     line_start,
    input  logic     frame_start,
    input  logic     fade_start,
    input  cidx_t    fade_colr,
    output logic     fb_we,
    output fb_addr_t fb_waddr,
    output cidx_t    fb_wdata,
    output logic     fetch_start,
    output fb_row_t  fetch_row,
    output logic     buf_swap,
    output fb_col_t  rd_col,
    output logic     paint_d,
    output logic     hsync,
    output logic     vsync,
    output logic     de,
    output logic     frame,
    output logic     fade_done
);

    localparam int RATEW = $clog2(`FADE_RATE);
    localparam int LINES = `FB_HEIGHT * `FB_SCALE;  // displayed lines

    ctrl_state_t        state;
    logic [RATEW-1:0]   rate_cnt;
    logic [7:0]         lfsr;
    logic [7:0]         lfsr_next;
    fb_addr_t           step_addr;
    logic               step;        // lfsr advances this cycle
    cidx_t              fade_idx;    // latched at start
    logic               group_top;   // first line of a scaled row
    logic               paint;
    logic [`PIX_LAT-1:0] hs_dly, vs_dly, de_dly, fr_dly;

    always_comb begin
        lfsr_next = {1'b0, lfsr[7:1]} ^ (lfsr[0] ? `LFSR_TAPS : 8'h00);  // galois shift
        step_addr = fb_addr_t'(lfsr_next - 1'b1);
        step      = (state == fading) && (rate_cnt == RATEW'(`FADE_RATE - 1));
        group_top = (sy % coord_t'(`FB_SCALE) == '0) && (sy < coord_t'(LINES));
        // fetch a group ahead, row 0 on the last blank line
        fetch_start = line_start && ((sy == coord_t'(`V_TOTAL - 1)) ||
                      (group_top && sy < coord_t'(LINES - `FB_SCALE)));
        fetch_row = (sy == coord_t'(`V_TOTAL - 1)) ? '0 :
                    fb_row_t'(sy / coord_t'(`FB_SCALE)) + 1'b1;
        buf_swap  = line_start && group_top;
        rd_col    = fb_col_t'(sx / coord_t'(`FB_SCALE));
        paint     = (sx < coord_t'(`FB_WIDTH * `FB_SCALE)) && (sy < coord_t'(LINES));
        fade_done = (state == done);
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            state    <= idle;
            rate_cnt <= '0;
            lfsr     <= `LFSR_SEED;
            fb_we    <= 1'b0;
        end else begin
            fb_we <= 1'b0;
            case (state)
                idle: if (fade_start) begin
                    state    <= fading;
                    rate_cnt <= '0;
                    lfsr     <= `LFSR_SEED;
                end
                fading: begin
                    rate_cnt <= step ? '0 : rate_cnt + 1'b1;
                    if (step) begin
                        lfsr  <= lfsr_next;
                        fb_we <= (step_addr < fb_addr_t'(`FB_PIXELS));  // skip off-image
                        if (lfsr_next == `LFSR_SEED) state <= done;    // full period
                    end
                end
                default: ;  // done holds until reset
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (state == idle && fade_start) fade_idx <= fade_colr;
        if (step) begin
            fb_waddr <= step_addr;
            fb_wdata <= fade_idx;
        end
    end

    // sync delay matches line store read plus clut
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            paint_d <= 1'b0;
            hs_dly  <= '0;
            vs_dly  <= '0;
            de_dly  <= '0;
            fr_dly  <= '0;
        end else begin
            paint_d <= paint;
            hs_dly  <= {hs_dly[`PIX_LAT-2:0], hsync_raw};
            vs_dly  <= {vs_dly[`PIX_LAT-2:0], vsync_raw};
            de_dly  <= {de_dly[`PIX_LAT-2:0], de_raw};
            fr_dly  <= {fr_dly[`PIX_LAT-2:0], frame_start};
        end
    end

    assign hsync = hs_dly[`PIX_LAT-1];
    assign vsync = vs_dly[`PIX_LAT-1];
    assign de    = de_dly[`PIX_LAT-1];
    assign frame = fr_dly[`PIX_LAT-1];

endmodule

// ==== logic/clut.sv ====
/* colour lookup table
   sixteen-entry palette, registered lookup, black outside the paint area */
module clut import fizzle_pkg::*; (
    input  logic  clk_sys,
    input  logic  pal_we,    // palette write
    input  cidx_t pal_idx,
    input  colr_t pal_colr,
    input  cidx_t cidx,      // pixel index from line store
    input  logic  paint,     // aligned with cidx
    output colr_t colr       // one cycle after cidx
);

    localparam int ENTRIES = 2 ** $bits(cidx_t);

    colr_t pal [ENTRIES];

    // write visible to the lookup on the following cycle
    always_ff @(posedge clk_sys) begin
        if (pal_we) pal[pal_idx] <= pal_colr;
    end

    always_ff @(posedge clk_sys) begin
        if (paint) begin
            colr <= pal[cidx];
        end else begin
            colr <= '0;  // blanking
        end
    end

endmodule

// ==== framebuffer/framebuffer.sv ====
/* framebuffer memory and row fetcher
   indexed pixel store with a write port, streams one row under credit control */
`include "fizzle_defs.svh"

module framebuffer import fizzle_pkg::*; (
    input  logic     clk_sys,
    input  logic     rst_n,
    input  logic     fb_we,          // fade write
    input  fb_addr_t fb_waddr,
    input  cidx_t    fb_wdata,
    input  logic     fetch_start,    // begin streaming a row
    input  fb_row_t  fetch_row,
    input  logic     credit_return,  // scaler freed a slot
    output logic     pix_valid,
    output cidx_t    pix_data
);

    localparam int CREDW = $clog2(`FETCH_CREDITS + 1);

    cidx_t            mem [`FB_PIXELS];
    logic             active;        // row in progress
    fb_row_t          row;
    fb_col_t          col;
    logic [CREDW-1:0] credits;
    logic             rd_fire;       // read issued this cycle
    fb_addr_t         rd_addr;

    // image starts as colour index 0 everywhere
    initial begin
        for (int i = 0; i < `FB_PIXELS; i++) begin
            mem[i] = '0;
        end
    end

    assign rd_fire = active && (credits != '0);  // stall on empty credit
    assign rd_addr = fb_addr_t'(row) * fb_addr_t'(`FB_WIDTH) + fb_addr_t'(col);

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            active    <= 1'b0;
            col       <= '0;
            credits   <= CREDW'(`FETCH_CREDITS);
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= rd_fire;  // data follows the read by a cycle
            credits   <= credits - CREDW'(rd_fire) + CREDW'(credit_return);
            if (fetch_start) begin
                active <= 1'b1;
                col    <= '0;
            end else if (rd_fire) begin
                col <= col + 1'b1;
                if (col == fb_col_t'(`FB_WIDTH - 1)) active <= 1'b0;  // row done
            end
        end
    end

    // memory write, row latch and registered read
    always_ff @(posedge clk_sys) begin
        if (fb_we) mem[fb_waddr] <= fb_wdata;
        if (fetch_start) row <= fetch_row;
        if (rd_fire) pix_data <= mem[rd_addr];
    end

endmodule

// ==== display/line_scaler.sv ====
/* double-buffered line scaler
   credit-returning staging fifo into ping-pong line stores, read by column */
`include "fizzle_defs.svh"

module line_scaler import fizzle_pkg::*; (
    input  logic    clk_sys,
    input  logic    rst_n,
    input  logic    pix_valid,      // word from framebuffer
    input  cidx_t   pix_data,
    output logic    credit_return,  // one pulse per drained word
    input  logic    buf_swap,       // new line group begins
    input  fb_col_t rd_col,         // display column / scale
    output cidx_t   lb_cidx         // one cycle after rd_col
);

    localparam int DEPTH = `FETCH_CREDITS;  // credits bound the occupancy
    localparam int PTRW  = $clog2(DEPTH);

    cidx_t           fifo_mem [DEPTH];
    logic [PTRW-1:0] wr_ptr;
    logic [PTRW-1:0] rd_ptr;
    logic [PTRW:0]   count;
    logic            pop;

    cidx_t           line_store [2][`FB_WIDTH];
    logic            front_sel;   // store being displayed
    fb_col_t         fill_col;    // next back-store column
    logic            rd_sel;

    assign pop = (count != '0);  // drain one word every cycle

    // swap lands at sx 0, so the first read already uses the new front
    assign rd_sel = front_sel ^ buf_swap;

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
            front_sel     <= 1'b0;
            fill_col      <= '0;
        end else begin
            if (pix_valid) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (PTRW+1)'(pix_valid) - (PTRW+1)'(pop);
            credit_return <= pop;  // credit back a cycle after the drain
            if (buf_swap) begin
                front_sel <= ~front_sel;
                fill_col  <= '0;   // back store refills from column 0
            end else if (pop) begin
                fill_col  <= fill_col + 1'b1;
            end
        end
    end

    // storage and the registered column read
    always_ff @(posedge clk_sys) begin
        if (pix_valid) fifo_mem[wr_ptr] <= pix_data;
        if (pop) line_store[~front_sel][fill_col] <= fifo_mem[rd_ptr];
        lb_cidx <= line_store[rd_sel][rd_col];  // repeats give the scale
    end

endmodule

// ==== display/display_timing.sv ====
/* display timing generator
   free-running counters giving coordinates, syncs, data enable and pulses */
`include "fizzle_defs.svh"

module display_timing import fizzle_pkg::*; (
    input  logic   clk_sys,
    input  logic   rst_n,
    output coord_t sx,           // horizontal position
    output coord_t sy,           // vertical position
    output logic   hsync_raw,    // active high
    output logic   vsync_raw,    // active high
    output logic   de_raw,       // inside active area
    output logic   line_start,   // sx back at 0
    output logic   frame_start   // sx and sy both 0
);

    // sync pulses sit right after the front porch
    localparam int HS_STA = `H_ACTIVE + `H_FP;
    localparam int HS_END = HS_STA + `H_SYNC;
    localparam int VS_STA = `V_ACTIVE + `V_FP;
    localparam int VS_END = VS_STA + `V_SYNC;

    logic h_last;  // final cycle of a line
    logic v_last;  // final line of a frame

    assign h_last = (sx == coord_t'(`H_TOTAL - 1));
    assign v_last = (sy == coord_t'(`V_TOTAL - 1));

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (h_last) begin
            sx <= '0;
            sy <= v_last ? '0 : sy + 1'b1;  // wrap at frame end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // decode straight from the counters
    always_comb begin
        hsync_raw   = (sx >= coord_t'(HS_STA)) && (sx < coord_t'(HS_END));
        vsync_raw   = (sy >= coord_t'(VS_STA)) && (sy < coord_t'(VS_END));
        de_raw      = (sx < coord_t'(`H_ACTIVE)) && (sy < coord_t'(`V_ACTIVE));
        line_start  = (sx == '0);
        frame_start = (sx == '0) && (sy == '0);
    end

endmodule

// ==== common/fizzle_pkg.sv ====
/* fizzle display types
   vector widths and the fade state encoding */
package fizzle_pkg;

    // colour
    typedef logic [3:0]  cidx_t;     // palette index
    typedef logic [3:0]  chan_t;     // one colour channel
    typedef logic [11:0] colr_t;     // {red, green, blue}

    // screen position, unsigned from first active pixel
    typedef logic [5:0]  coord_t;

    // framebuffer addressing
    typedef logic [7:0]  fb_addr_t;  // 192 entries
    typedef logic [3:0]  fb_col_t;
    typedef logic [3:0]  fb_row_t;

    // fade sequencer
    typedef enum logic [1:0] {
        idle,                        // waiting for fade_start
        fading,                      // lfsr stepping
        done                         // every pixel written
    } ctrl_state_t;

endpackage

// ==== common/fizzle_defs.svh ====
/* fizzle display constants
   display timing, framebuffer geometry, fade rate and flow control */
`ifndef FIZZLE_DEFS_SVH
`define FIZZLE_DEFS_SVH

// horizontal timing in clk_sys cycles
`define H_ACTIVE      32
`define H_FP          2
`define H_SYNC        4
`define H_BP          2
`define H_TOTAL       (`H_ACTIVE + `H_FP + `H_SYNC + `H_BP)

// vertical timing in lines
`define V_ACTIVE      24
`define V_FP          1
`define V_SYNC        2
`define V_BP          1
`define V_TOTAL       (`V_ACTIVE + `V_FP + `V_SYNC + `V_BP)

`define FB_WIDTH      16                       // framebuffer pixels per row
`define FB_HEIGHT     12                       // framebuffer rows
`define FB_PIXELS     (`FB_WIDTH * `FB_HEIGHT)
`define FB_SCALE      2                        // integer display scale

`define FADE_RATE     16                       // cycles per lfsr step
`define LFSR_SEED     8'h01
`define LFSR_TAPS     8'hb8                    // x^8+x^6+x^5+x^4+1, galois form
`define FETCH_CREDITS 4                        // words in flight fb to scaler
`define PIX_LAT       2                        // coords to colour, in cycles

`endif
